// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_spmm_result_store
FILELIST := verilog.f
OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
PASS_MSG := *** PASSED ***

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: graph_types_pkg.sv
// ==========================================================================
// Graph quantity widths and vector types, node-count controller states
// ==========================================================================

`default_nettype none

package graph_types_pkg;

  // ========================================================================
  // Graph dimensions
  // ========================================================================
  // Largest subgraph, sets the node count width
  localparam int MAX_NODES       = 168;
  // WH products per node row
  localparam int NUM_FEATURE_OUT = 16;
  localparam int WH_ELEM_WIDTH   = 12;

  // ========================================================================
  // Vector types
  // ========================================================================
  typedef logic [$clog2(MAX_NODES)-1:0] num_node_t;
  typedef logic [WH_ELEM_WIDTH-1:0]     wh_elem_t;

  // Element 0 sits in the low bits of the row
  typedef wh_elem_t [NUM_FEATURE_OUT-1:0] wh_row_t;

  // Node-count controller
  typedef enum logic [1:0] {
    IDLE     = 2'b00,
    WRITE    = 2'b01,
    IN_GRAPH = 2'b10
  } node_ctrl_state_t;

endpackage

`default_nettype wire

// File: num_node_controller.sv
// ==========================================================================
// Node-count controller, one count per subgraph at consecutive addresses
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module num_node_controller import graph_types_pkg::*; #(
  parameter int NUM_SUBGRAPHS = 2708
) (
  input  logic                             clk,
  input  logic                             rst_n,

  input  logic                             spmm_vld,
  input  logic                             src_flag,
  input  num_node_t                        num_node,

  // Node-count memory write port
  output logic                             num_node_wr_en,
  output logic [$clog2(NUM_SUBGRAPHS)-1:0] num_node_wr_addr,
  output num_node_t                        num_node_wr_data,

  output logic [$clog2(NUM_SUBGRAPHS)-1:0] subgraph_count
);

  localparam int SG_ADDR_W = $clog2(NUM_SUBGRAPHS);

  node_ctrl_state_t       state, state_nxt;
  logic [SG_ADDR_W-1:0]   sg_addr;
  num_node_t              num_node_q;
  logic                   src_beat;

  assign src_beat = spmm_vld & src_flag;

  // ========================================================================
  // State machine
  // ========================================================================
  always_comb begin
    state_nxt = state;
    if (src_beat) begin
      // Every source beat starts a fresh write
      state_nxt = WRITE;
    end else begin
      case (state)
        WRITE:    state_nxt = IN_GRAPH;
        IN_GRAPH: if (spmm_vld) state_nxt = IDLE;
        default:  state_nxt = state;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      sg_addr <= '0;
    end else begin
      state <= state_nxt;
      if (state == WRITE) begin
        // Wrap at the memory depth
        sg_addr <= (sg_addr == SG_ADDR_W'(NUM_SUBGRAPHS - 1)) ? '0 : sg_addr + 1'b1;
      end
    end
  end

  // Count captured on the source beat itself
  always_ff @(posedge clk) begin
    if (src_beat) begin
      num_node_q <= num_node;
    end
  end

  assign num_node_wr_en   = (state == WRITE);
  assign num_node_wr_addr = sg_addr;
  assign num_node_wr_data = num_node_q;
  assign subgraph_count   = sg_addr;

endmodule

`default_nettype wire

// File: simple_dual_port_bram.sv
// ==========================================================================
// Simple dual-port memory, one write port and one registered read port
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module simple_dual_port_bram #(
  parameter int DEPTH = 1024,
  parameter int WIDTH = 32
) (
  input  logic                     clk,

  // Write port
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  logic [WIDTH-1:0]         wr_data,

  // Read port, one cycle latency
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output logic [WIDTH-1:0]         rd_data
);

  logic [WIDTH-1:0] mem [DEPTH];

  // ========================================================================
  // Write
  // ========================================================================
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ========================================================================
  // Registered read
  // ========================================================================
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: spmm_result_store.sv
// ==========================================================================
// SpMM result store top level: node-count and WH writers, their memories
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module spmm_result_store import graph_types_pkg::*, spmm_stream_pkg::*; #(
  parameter int TOTAL_NODES   = 13264,
  parameter int NUM_SUBGRAPHS = 2708
) (
  input  logic                             clk,
  input  logic                             rst_n,

  // SpMM output stream
  input  logic                             spmm_vld,
  input  spmm_beat_t                       spmm_beat,

  // Read ports
  input  logic [$clog2(NUM_SUBGRAPHS)-1:0] num_node_rd_addr,
  output num_node_t                        num_node_rd_data,
  input  logic [$clog2(TOTAL_NODES)-1:0]   wh_rd_addr,
  output wh_word_t                         wh_rd_data,

  // Fill levels
  output logic [$clog2(NUM_SUBGRAPHS)-1:0] subgraph_count,
  output logic [$clog2(TOTAL_NODES)-1:0]   node_count
);

  localparam int SG_ADDR_W   = $clog2(NUM_SUBGRAPHS);
  localparam int NODE_ADDR_W = $clog2(TOTAL_NODES);

  logic                   num_node_wr_en;
  logic [SG_ADDR_W-1:0]   num_node_wr_addr;
  num_node_t              num_node_wr_data;

  logic                   wh_wr_en;
  logic [NODE_ADDR_W-1:0] wh_wr_addr;
  wh_word_t               wh_wr_data;

  // ========================================================================
  // Node-count path
  // ========================================================================
  num_node_controller #(
    .NUM_SUBGRAPHS (NUM_SUBGRAPHS)
  ) num_node_controller_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .spmm_vld         (spmm_vld),
    .src_flag         (spmm_beat.src_flag),
    .num_node         (spmm_beat.num_node),
    .num_node_wr_en   (num_node_wr_en),
    .num_node_wr_addr (num_node_wr_addr),
    .num_node_wr_data (num_node_wr_data),
    .subgraph_count   (subgraph_count)
  );

  simple_dual_port_bram #(
    .DEPTH (NUM_SUBGRAPHS),
    .WIDTH ($bits(num_node_t))
  ) num_node_bram_i (
    .clk     (clk),
    .wr_en   (num_node_wr_en),
    .wr_addr (num_node_wr_addr),
    .wr_data (num_node_wr_data),
    .rd_addr (num_node_rd_addr),
    .rd_data (num_node_rd_data)
  );

  // ========================================================================
  // WH path
  // ========================================================================
  wh_result_writer #(
    .TOTAL_NODES (TOTAL_NODES)
  ) wh_result_writer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .spmm_vld   (spmm_vld),
    .spmm_beat  (spmm_beat),
    .wh_wr_en   (wh_wr_en),
    .wh_wr_addr (wh_wr_addr),
    .wh_wr_data (wh_wr_data),
    .node_count (node_count)
  );

  simple_dual_port_bram #(
    .DEPTH (TOTAL_NODES),
    .WIDTH ($bits(wh_word_t))
  ) wh_bram_i (
    .clk     (clk),
    .wr_en   (wh_wr_en),
    .wr_addr (wh_wr_addr),
    .wr_data (wh_wr_data),
    .rd_addr (wh_rd_addr),
    .rd_data (wh_rd_data)
  );

endmodule

`default_nettype wire

// File: spmm_stream_pkg.sv
// ==========================================================================
// SpMM output beat and stored WH word structs
// ==========================================================================

`default_nettype none

package spmm_stream_pkg;

  import graph_types_pkg::*;

  // One beat per graph node from the SpMM unit
  typedef struct packed {
    logic      src_flag;
    num_node_t num_node;
    wh_row_t   wh_row;
  } spmm_beat_t;

  // WH memory word, count and flag appended below the row
  // Flag ends up in bit 0
  typedef struct packed {
    wh_row_t   wh_row;
    num_node_t num_node;
    logic      src_flag;
  } wh_word_t;

endpackage

`default_nettype wire

// File: tb_spmm_result_store.sv
// ==========================================================================
// Directed testbench for the SpMM result store, reference queues and checks
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module tb_spmm_result_store import graph_types_pkg::*, spmm_stream_pkg::*; ();

  localparam int TOTAL_NODES   = 64;
  localparam int NUM_SUBGRAPHS = 32;
  localparam int SG_W          = $clog2(NUM_SUBGRAPHS);
  localparam int NODE_W        = $clog2(TOTAL_NODES);
  localparam int TIMEOUT       = 200;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              spmm_vld;
  spmm_beat_t        spmm_beat;
  logic [SG_W-1:0]   num_node_rd_addr;
  num_node_t         num_node_rd_data;
  logic [NODE_W-1:0] wh_rd_addr;
  wh_word_t          wh_rd_data;
  logic [SG_W-1:0]   subgraph_count;
  logic [NODE_W-1:0] node_count;

  integer seed;
  int     errors;
  int     checks;

  // Reference model, in address order
  num_node_t exp_num_node[$];
  wh_word_t  exp_wh[$];

  always #50 clk = ~clk;

  spmm_result_store #(
    .TOTAL_NODES   (TOTAL_NODES),
    .NUM_SUBGRAPHS (NUM_SUBGRAPHS)
  ) spmm_result_store_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .spmm_vld         (spmm_vld),
    .spmm_beat        (spmm_beat),
    .num_node_rd_addr (num_node_rd_addr),
    .num_node_rd_data (num_node_rd_data),
    .wh_rd_addr       (wh_rd_addr),
    .wh_rd_data       (wh_rd_data),
    .subgraph_count   (subgraph_count),
    .node_count       (node_count)
  );

  // ========================================================================
  // Compare tasks
  // ========================================================================
  task automatic check_num_node(input string name, input num_node_t exp, input num_node_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
    end
  endtask

  task automatic check_wh_word(input string name, input wh_word_t exp, input wh_word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
    end
  endtask

  task automatic check_subgraph_count(input logic [SG_W-1:0] exp, input logic [SG_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED subgraph_count: expected 0x%h, got 0x%h", exp, act);
    end
  endtask

  task automatic check_node_count(input logic [NODE_W-1:0] exp, input logic [NODE_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED node_count: expected 0x%h, got 0x%h", exp, act);
    end
  endtask

  // ========================================================================
  // Stimulus
  // ========================================================================
  task automatic idle_cycles(input int k);
    repeat (k) begin
      @(negedge clk);
      spmm_vld = 1'b0;
    end
  endtask

  // n beats, up to gap idle cycles after each one
  task automatic send_subgraph(input int n, input int gap);
    spmm_beat_t beat;
    wh_word_t   word;
    int         i;
    int         e;
    int         idle;
    for (i = 0; i < n; i++) begin
      for (e = 0; e < NUM_FEATURE_OUT; e++) begin
        beat.wh_row[e] = wh_elem_t'($random(seed));
      end
      beat.src_flag = (i == 0);
      beat.num_node = num_node_t'(n);
      // Stored word is row, then count, then flag
      word.wh_row   = beat.wh_row;
      word.num_node = num_node_t'(n);
      word.src_flag = (i == 0);
      @(negedge clk);
      spmm_vld  = 1'b1;
      spmm_beat = beat;
      exp_wh.push_back(word);
      if (i == 0) begin
        exp_num_node.push_back(num_node_t'(n));
      end
      if (gap > 0) begin
        idle = {$random(seed)} % (gap + 1);
        idle_cycles(idle);
      end
    end
  endtask

  // Both fill levels must settle at the reference totals
  task automatic wait_for_counts;
    int                cycles;
    logic [SG_W-1:0]   exp_sg;
    logic [NODE_W-1:0] exp_nodes;
    exp_sg    = SG_W'(exp_num_node.size());
    exp_nodes = NODE_W'(exp_wh.size());
    cycles    = 0;
    while ((subgraph_count !== exp_sg || node_count !== exp_nodes) && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= TIMEOUT) begin
      errors++;
      $display("Timed out after %0d cycles waiting for %0d subgraphs and %0d nodes",
               TIMEOUT, exp_sg, exp_nodes);
    end
    // Input is idle, so no further write may move the counts
    repeat (2) @(negedge clk);
    check_subgraph_count(exp_sg, subgraph_count);
    check_node_count(exp_nodes, node_count);
  endtask

  task automatic read_back;
    int a;
    for (a = 0; a < exp_num_node.size(); a++) begin
      @(negedge clk);
      num_node_rd_addr = SG_W'(a);
      @(negedge clk);
      check_num_node($sformatf("num_node_rd_data[%0d]", a), exp_num_node[a], num_node_rd_data);
    end
    for (a = 0; a < exp_wh.size(); a++) begin
      @(negedge clk);
      wh_rd_addr = NODE_W'(a);
      @(negedge clk);
      check_wh_word($sformatf("wh_rd_data[%0d]", a), exp_wh[a], wh_rd_data);
    end
  endtask

  // ========================================================================
  // Directed tests
  // ========================================================================
  task automatic test_reset;
    $display("Test: counts after reset");
    check_subgraph_count('0, subgraph_count);
    check_node_count('0, node_count);
  endtask

  task automatic test_back_to_back;
    $display("Test: back-to-back subgraphs");
    repeat (4) send_subgraph(1 + {$random(seed)} % 6, 0);
    idle_cycles(1);
    wait_for_counts();
  endtask

  task automatic test_random_gaps;
    $display("Test: idle gaps between beats and subgraphs");
    repeat (4) begin
      send_subgraph(1 + {$random(seed)} % 6, 3);
      idle_cycles({$random(seed)} % 4);
    end
    idle_cycles(1);
    wait_for_counts();
  endtask

  // Source-only subgraphs in consecutive cycles
  task automatic test_single_node;
    $display("Test: consecutive one-node subgraphs");
    repeat (4) send_subgraph(1, 0);
    send_subgraph(3, 0);
    idle_cycles(1);
    wait_for_counts();
  endtask

  initial begin
    seed             = 32'h6f84_20a3;
    errors           = 0;
    checks           = 0;
    rst_n            = 1'b0;
    spmm_vld         = 1'b0;
    spmm_beat        = '0;
    num_node_rd_addr = '0;
    wh_rd_addr       = '0;

    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    test_reset();
    test_back_to_back();
    test_random_gaps();
    test_single_node();
    $display("Test: read back both memories");
    read_back();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
graph_types_pkg.sv
spmm_stream_pkg.sv
simple_dual_port_bram.sv
num_node_controller.sv
wh_result_writer.sv
spmm_result_store.sv
tb_spmm_result_store.sv

// File: wh_result_writer.sv
// ==========================================================================
// WH result writer, one WH word per SpMM beat at consecutive addresses
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module wh_result_writer import spmm_stream_pkg::*; #(
  parameter int TOTAL_NODES = 13264
) (
  input  logic                           clk,
  input  logic                           rst_n,

  input  logic                           spmm_vld,
  input  spmm_beat_t                     spmm_beat,

  // WH memory write port
  output logic                           wh_wr_en,
  output logic [$clog2(TOTAL_NODES)-1:0] wh_wr_addr,
  output wh_word_t                       wh_wr_data,

  output logic [$clog2(TOTAL_NODES)-1:0] node_count
);

  localparam int NODE_ADDR_W = $clog2(TOTAL_NODES);

  logic                   wr_en_q;
  logic [NODE_ADDR_W-1:0] node_addr;
  wh_word_t               wh_word_q;

  // Repack beat as a memory word
  always_ff @(posedge clk) begin
    if (spmm_vld) begin
      wh_word_q.wh_row   <= spmm_beat.wh_row;
      wh_word_q.num_node <= spmm_beat.num_node;
      wh_word_q.src_flag <= spmm_beat.src_flag;
    end
  end

  // ========================================================================
  // Write enable and node address
  // ========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_en_q   <= 1'b0;
      node_addr <= '0;
    end else begin
      wr_en_q <= spmm_vld;
      if (wr_en_q) begin
        node_addr <= (node_addr == NODE_ADDR_W'(TOTAL_NODES - 1)) ? '0 : node_addr + 1'b1;
      end
    end
  end

  assign wh_wr_en   = wr_en_q;
  assign wh_wr_addr = node_addr;
  assign wh_wr_data = wh_word_q;
  assign node_count = node_addr;

endmodule

`default_nettype wire
